/* commit_window.f */
hw/commit_cfg_pkg.sv
hw/commit_op_pkg.sv
hw/slot_bus_if.sv
hw/ring_ctrl.sv
hw/commit_slot.sv
hw/issue_select.sv
hw/retire_scan.sv
hw/commit_window.sv
verification/commit_window_tb.sv

/* Bender.yml */
package:
  name: commit_window

sources:
  - hw/commit_cfg_pkg.sv
  - hw/commit_op_pkg.sv
  - hw/slot_bus_if.sv
  - hw/ring_ctrl.sv
  - hw/commit_slot.sv
  - hw/issue_select.sv
  - hw/retire_scan.sv
  - hw/commit_window.sv
  - target: simulation
    files:
      - verification/commit_window_tb.sv

/* verification/commit_window_tb.sv */
// commit window testbench: directed tests against a cycle model of the ring, issue and retire
`default_nettype none
`timescale 1ns/1ps

module commit_window_tb
	import commit_cfg_pkg::*;
	import commit_op_pkg::*;
();

	// rough cycle budget per test, summed for the watchdog
	localparam int TEST_CYCLES = 2 + 70 + 120 + 60 + 60 + 300;
	localparam int WATCHDOG_NS = TEST_CYCLES * 4 * 2;

	logic clk;
	logic reset;
	logic disp_valid;
	logic disp_ready;
	tag_t disp_tag;
	unit_kind_e disp_unit;
	logic [RD_BITS-1:0] disp_rd;
	logic disp_src1_valid;
	tag_t disp_src1_tag;
	logic disp_src2_valid;
	tag_t disp_src2_tag;
	logic issue_valid;
	logic issue_ready;
	tag_t issue_tag;
	unit_kind_e issue_unit;
	logic [RD_BITS-1:0] issue_rd;
	logic ld_done_valid;
	tag_t ld_done_tag;
	logic retire_valid;
	logic retire_ready;
	count_t retire_count;
	tag_t retire_head_tag;
	logic [RD_BITS-1:0] retire_rd0;
	logic [RD_BITS-1:0] retire_rd1;

	// window model, indexed by slot tag, with program order in mq
	tag_t mq[$];
	tag_t m_tail;
	logic m_live[NUM_ENTRIES];
	logic m_issued[NUM_ENTRIES];
	logic m_done[NUM_ENTRIES];
	logic m_res1[NUM_ENTRIES];
	logic m_res2[NUM_ENTRIES];
	tag_t m_dep1[NUM_ENTRIES];
	tag_t m_dep2[NUM_ENTRIES];
	unit_kind_e m_unit[NUM_ENTRIES];
	logic [RD_BITS-1:0] m_rd[NUM_ENTRIES];
	int m_lat[NUM_ENTRIES];

	// what the DUT showed at the last sample point
	logic dut_issued[NUM_ENTRIES];
	logic [RD_BITS-1:0] ret_rds[$];
	logic last_disp_fire;
	logic last_disp_ready;
	tag_t last_disp_tag;
	logic last_issue_valid;
	tag_t last_issue_tag;
	logic last_retire_valid;
	tag_t last_retire_head;
	count_t last_retire_count;

	logic [31:0] lfsr;
	int errors;
	int checks;

	commit_window uut (
		.clk(clk),
		.reset(reset),
		.disp_valid(disp_valid),
		.disp_ready(disp_ready),
		.disp_tag(disp_tag),
		.disp_unit(disp_unit),
		.disp_rd(disp_rd),
		.disp_src1_valid(disp_src1_valid),
		.disp_src1_tag(disp_src1_tag),
		.disp_src2_valid(disp_src2_valid),
		.disp_src2_tag(disp_src2_tag),
		.issue_valid(issue_valid),
		.issue_ready(issue_ready),
		.issue_tag(issue_tag),
		.issue_unit(issue_unit),
		.issue_rd(issue_rd),
		.ld_done_valid(ld_done_valid),
		.ld_done_tag(ld_done_tag),
		.retire_valid(retire_valid),
		.retire_ready(retire_ready),
		.retire_count(retire_count),
		.retire_head_tag(retire_head_tag),
		.retire_rd0(retire_rd0),
		.retire_rd1(retire_rd1)
	);

	always #2 clk = ~clk;

	// galois lfsr, one step per bit
	function automatic logic [31:0] lfsr_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("mismatch %s at %0t: got %h expected %h", name, $time, got, exp);
		end
	endtask

	task automatic check_tag(input string name, input tag_t got, input tag_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("mismatch %s at %0t: got %h expected %h", name, $time, got, exp);
		end
	endtask

	task automatic check_count(input string name, input count_t got, input count_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("mismatch %s at %0t: got %h expected %h", name, $time, got, exp);
		end
	endtask

	task automatic check_unit(input string name, input unit_kind_e got, input unit_kind_e exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("mismatch %s at %0t: got %h expected %h", name, $time, got, exp);
		end
	endtask

	task automatic check_rd(input string name, input logic [RD_BITS-1:0] got,
		input logic [RD_BITS-1:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("mismatch %s at %0t: got %h expected %h", name, $time, got, exp);
		end
	endtask

	// one clock: compare outputs to the model, then advance the model at the rising edge
	task automatic run_cycle();
		logic found;
		logic stop;
		logic d_fire;
		logic i_fire;
		logic r_fire;
		tag_t pick;
		tag_t t;
		int n;
		slot_vec_t fin;
		#1;
		found = 1'b0;
		pick = '0;
		foreach (mq[i]) begin
			if (!found && !m_issued[mq[i]] && m_res1[mq[i]] && m_res2[mq[i]]) begin
				found = 1'b1;
				pick = mq[i];
			end
		end
		n = 0;
		stop = 1'b0;
		for (int i = 0; i < RETIRE_WIDTH && i < mq.size(); i++) begin
			if (!stop && m_done[mq[i]]) begin
				n++;
			end else begin
				stop = 1'b1;
			end
		end
		check_bit("disp_ready", disp_ready, mq.size() < NUM_ENTRIES);
		check_tag("disp_tag", disp_tag, m_tail);
		check_bit("issue_valid", issue_valid, found);
		if (found && issue_valid) begin
			check_tag("issue_tag", issue_tag, pick);
			check_unit("issue_unit", issue_unit, m_unit[pick]);
			check_rd("issue_rd", issue_rd, m_rd[pick]);
		end
		check_bit("retire_valid", retire_valid, n > 0);
		check_count("retire_count", retire_count, count_t'(n));
		if (n > 0) begin
			check_tag("retire_head_tag", retire_head_tag, mq[0]);
			check_rd("retire_rd0", retire_rd0, m_rd[mq[0]]);
			if (n == 2) begin
				check_rd("retire_rd1", retire_rd1, m_rd[mq[1]]);
			end
		end
		last_disp_ready = disp_ready;
		last_disp_tag = disp_tag;
		last_issue_valid = issue_valid;
		last_issue_tag = issue_tag;
		last_retire_valid = retire_valid;
		last_retire_head = retire_head_tag;
		last_retire_count = retire_count;
		if (issue_valid && issue_ready) begin
			dut_issued[issue_tag] = 1'b1;
		end
		if (retire_valid && retire_ready) begin
			ret_rds.push_back(retire_rd0);
			if (retire_count == 2) begin
				ret_rds.push_back(retire_rd1);
			end
		end
		d_fire = disp_valid && (mq.size() < NUM_ENTRIES);
		i_fire = issue_ready && found;
		r_fire = retire_ready && (n > 0);
		@(posedge clk);
		// dispatch sees the window as it was before this edge
		if (d_fire) begin
			t = m_tail;
			m_res1[t] = !disp_src1_valid || !m_live[disp_src1_tag] || m_done[disp_src1_tag];
			m_res2[t] = !disp_src2_valid || !m_live[disp_src2_tag] || m_done[disp_src2_tag];
			m_dep1[t] = disp_src1_tag;
			m_dep2[t] = disp_src2_tag;
			m_unit[t] = disp_unit;
			m_rd[t] = disp_rd;
			m_live[t] = 1'b1;
			m_issued[t] = 1'b0;
			m_done[t] = 1'b0;
			dut_issued[t] = 1'b0;
			mq.push_back(t);
			m_tail = m_tail + 1'b1;
		end
		fin = '0;
		for (int s = 0; s < NUM_ENTRIES; s++) begin
			if (m_live[s] && m_issued[s] && !m_done[s]) begin
				if (m_unit[s] == UNIT_LOAD) begin
					fin[s] = ld_done_valid && (ld_done_tag == tag_t'(s));
				end else begin
					m_lat[s]--;
					fin[s] = (m_lat[s] == 0);
				end
			end
		end
		for (int c = 0; c < NUM_ENTRIES; c++) begin
			if (fin[c]) begin
				m_done[c] = 1'b1;
			end
			if (m_live[c] && !m_res1[c] && fin[m_dep1[c]]) begin
				m_res1[c] = 1'b1;
			end
			if (m_live[c] && !m_res2[c] && fin[m_dep2[c]]) begin
				m_res2[c] = 1'b1;
			end
		end
		if (i_fire) begin
			m_issued[pick] = 1'b1;
			m_lat[pick] = (m_unit[pick] == UNIT_MUL) ? MUL_LATENCY : 1;
		end
		if (r_fire) begin
			repeat (n) begin
				t = mq.pop_front();
				m_live[t] = 1'b0;
				m_done[t] = 1'b0;
				m_issued[t] = 1'b0;
			end
		end
		last_disp_fire = d_fire;
		@(negedge clk);
		ld_done_valid = 1'b0;
	endtask

	// an in-flight load picked by position, or -1 when none
	function automatic int find_busy_load(input int skip);
		int cnt;
		int k;
		cnt = 0;
		for (int s = 0; s < NUM_ENTRIES; s++) begin
			if (m_live[s] && m_issued[s] && !m_done[s] && m_unit[s] == UNIT_LOAD) begin
				cnt++;
			end
		end
		if (cnt == 0) begin
			return -1;
		end
		k = skip % cnt;
		for (int s = 0; s < NUM_ENTRIES; s++) begin
			if (m_live[s] && m_issued[s] && !m_done[s] && m_unit[s] == UNIT_LOAD) begin
				if (k == 0) begin
					return s;
				end
				k--;
			end
		end
		return -1;
	endfunction

	task automatic dispatch_op(input unit_kind_e unit, input logic [RD_BITS-1:0] rd,
		input logic s1v, input tag_t s1t, input logic s2v, input tag_t s2t, output tag_t tag);
		int waited;
		disp_unit = unit;
		disp_rd = rd;
		disp_src1_valid = s1v;
		disp_src1_tag = s1t;
		disp_src2_valid = s2v;
		disp_src2_tag = s2t;
		disp_valid = 1'b1;
		waited = 0;
		do begin
			run_cycle();
			waited++;
		end while (!last_disp_fire && waited < 50);
		if (!last_disp_fire) begin
			errors++;
			$display("dispatch was not accepted within 50 cycles");
		end
		tag = last_disp_tag;
		disp_valid = 1'b0;
	endtask

	task automatic wait_issued(input tag_t tag, input int limit);
		int waited;
		waited = 0;
		while (!dut_issued[tag] && waited < limit) begin
			run_cycle();
			waited++;
		end
		if (!dut_issued[tag]) begin
			errors++;
			$display("slot %0d was not issued within %0d cycles", tag, limit);
		end
	endtask

	// run until the window is empty, completing loads oldest slot first
	task automatic drain(input int limit);
		int waited;
		int lt;
		issue_ready = 1'b1;
		retire_ready = 1'b1;
		waited = 0;
		while (mq.size() != 0 && waited < limit) begin
			lt = find_busy_load(0);
			if (lt >= 0) begin
				ld_done_tag = tag_t'(lt);
				ld_done_valid = 1'b1;
			end
			run_cycle();
			waited++;
		end
		if (mq.size() != 0) begin
			errors++;
			$display("window did not empty within %0d cycles", limit);
		end
	endtask

	task automatic report_test(input string name, input int errors_before);
		if (errors == errors_before) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: %0d errors", name, errors - errors_before);
		end
	endtask

	task automatic test_reset();
		int e0;
		e0 = errors;
		run_cycle();
		check_bit("disp_ready", last_disp_ready, 1'b1);
		check_bit("issue_valid", last_issue_valid, 1'b0);
		check_bit("retire_valid", last_retire_valid, 1'b0);
		report_test("reset", e0);
	endtask

	task automatic test_fill();
		int e0;
		tag_t tag;
		e0 = errors;
		issue_ready = 1'b0;
		retire_ready = 1'b0;
		for (int i = 0; i < NUM_ENTRIES; i++) begin
			dispatch_op(UNIT_ALU, RD_BITS'(i + 1), 1'b0, '0, 1'b0, '0, tag);
			check_tag("disp_tag", tag, tag_t'(i));
		end
		run_cycle();
		check_bit("disp_ready", last_disp_ready, 1'b0);
		drain(60);
		run_cycle();
		check_bit("disp_ready", last_disp_ready, 1'b1);
		check_tag("disp_tag", last_disp_tag, '0);
		report_test("fill", e0);
	endtask

	task automatic test_dep();
		int e0;
		tag_t ld;
		tag_t a;
		tag_t b;
		e0 = errors;
		issue_ready = 1'b1;
		retire_ready = 1'b1;
		dispatch_op(UNIT_LOAD, 5'd10, 1'b0, '0, 1'b0, '0, ld);
		dispatch_op(UNIT_ALU, 5'd11, 1'b1, ld, 1'b0, '0, a);
		dispatch_op(UNIT_ALU, 5'd12, 1'b0, '0, 1'b0, '0, b);
		wait_issued(ld, 20);
		wait_issued(b, 20);
		repeat (4) run_cycle();
		check_bit("consumer_issued", dut_issued[a], 1'b0);
		ld_done_tag = ld;
		ld_done_valid = 1'b1;
		run_cycle();
		wait_issued(a, 20);
		drain(40);
		report_test("dependence", e0);
	endtask

	task automatic test_oldest();
		int e0;
		tag_t t[4];
		e0 = errors;
		issue_ready = 1'b0;
		retire_ready = 1'b1;
		for (int i = 0; i < 4; i++) begin
			dispatch_op(UNIT_MUL, RD_BITS'(20 + i), 1'b0, '0, 1'b0, '0, t[i]);
		end
		repeat (3) begin
			run_cycle();
			check_bit("issue_valid", last_issue_valid, 1'b1);
			check_tag("issue_tag", last_issue_tag, t[0]);
		end
		issue_ready = 1'b1;
		run_cycle();
		issue_ready = 1'b0;
		repeat (2) begin
			run_cycle();
			check_tag("issue_tag", last_issue_tag, t[1]);
		end
		drain(40);
		report_test("oldest_first", e0);
	endtask

	task automatic test_order();
		int e0;
		int waited;
		tag_t t[4];
		e0 = errors;
		issue_ready = 1'b1;
		retire_ready = 1'b0;
		for (int i = 0; i < 4; i++) begin
			dispatch_op(UNIT_LOAD, RD_BITS'(i + 1), 1'b0, '0, 1'b0, '0, t[i]);
		end
		for (int i = 0; i < 4; i++) begin
			wait_issued(t[i], 20);
		end
		ret_rds.delete();
		// youngest load finishes first
		for (int k = 3; k >= 0; k--) begin
			ld_done_tag = t[k];
			ld_done_valid = 1'b1;
			run_cycle();
		end
		repeat (3) begin
			run_cycle();
			check_bit("retire_valid", last_retire_valid, 1'b1);
			check_tag("retire_head_tag", last_retire_head, t[0]);
			// all four are done but the scan stops at the retire width
			check_count("retire_count", last_retire_count, count_t'(RETIRE_WIDTH));
		end
		retire_ready = 1'b1;
		waited = 0;
		while (ret_rds.size() < 4 && waited < 20) begin
			run_cycle();
			waited++;
		end
		if (ret_rds.size() < 4) begin
			errors++;
			$display("only %0d of 4 loads retired", ret_rds.size());
		end else begin
			for (int i = 0; i < 4; i++) begin
				check_rd("retired_rd", ret_rds[i], RD_BITS'(i + 1));
			end
		end
		report_test("in_order_retire", e0);
	endtask

	task automatic test_random();
		int e0;
		int lt;
		e0 = errors;
		for (int c = 0; c < 200; c++) begin
			// a raised dispatch keeps its payload until accepted
			if (!disp_valid && lfsr_bits(1)) begin
				disp_unit = unit_kind_e'(lfsr_bits(2) % 3);
				disp_rd = RD_BITS'(lfsr_bits(RD_BITS));
				disp_src1_valid = lfsr_bits(1);
				disp_src1_tag = tag_t'(lfsr_bits(TAG_BITS));
				disp_src2_valid = lfsr_bits(1);
				disp_src2_tag = tag_t'(lfsr_bits(TAG_BITS));
				disp_valid = 1'b1;
			end
			issue_ready = (lfsr_bits(2) != 0);
			retire_ready = (lfsr_bits(2) != 0);
			lt = find_busy_load(lfsr_bits(3));
			if (lt >= 0 && lfsr_bits(1)) begin
				ld_done_tag = tag_t'(lt);
				ld_done_valid = 1'b1;
			end
			run_cycle();
			if (last_disp_fire) begin
				disp_valid = 1'b0;
			end
		end
		disp_valid = 1'b0;
		drain(100);
		report_test("random", e0);
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
		$display("Result: FAILED");
		$finish;
	end

	initial begin
		clk = 1'b0;
		reset = 1'b1;
		disp_valid = 1'b0;
		disp_unit = UNIT_ALU;
		disp_rd = '0;
		disp_src1_valid = 1'b0;
		disp_src1_tag = '0;
		disp_src2_valid = 1'b0;
		disp_src2_tag = '0;
		issue_ready = 1'b0;
		ld_done_valid = 1'b0;
		ld_done_tag = '0;
		retire_ready = 1'b0;
		lfsr = 32'h87d4;
		errors = 0;
		checks = 0;
		m_tail = '0;
		mq.delete();
		for (int s = 0; s < NUM_ENTRIES; s++) begin
			m_live[s] = 1'b0;
			m_issued[s] = 1'b0;
			m_done[s] = 1'b0;
			dut_issued[s] = 1'b0;
			m_lat[s] = 0;
		end
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		test_reset();
		test_fill();
		test_dep();
		test_oldest();
		test_order();
		test_random();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* hw/commit_window.sv */
// in-order commit window top: ring control, slot array, issue selector and retire scan
`default_nettype none
`timescale 1ns/1ps

module commit_window
	import commit_cfg_pkg::*;
	import commit_op_pkg::*;
(
	input wire logic clk,
	input wire logic reset,
	// dispatch
	input wire logic disp_valid,
	output logic disp_ready,
	output tag_t disp_tag,
	input wire unit_kind_e disp_unit,
	input wire logic [RD_BITS-1:0] disp_rd,
	input wire logic disp_src1_valid,
	input wire tag_t disp_src1_tag,
	input wire logic disp_src2_valid,
	input wire tag_t disp_src2_tag,
	// issue
	output logic issue_valid,
	input wire logic issue_ready,
	output tag_t issue_tag,
	output unit_kind_e issue_unit,
	output logic [RD_BITS-1:0] issue_rd,
	// load completion pulse
	input wire logic ld_done_valid,
	input wire tag_t ld_done_tag,
	// retirement
	output logic retire_valid,
	input wire logic retire_ready,
	output count_t retire_count,
	output tag_t retire_head_tag,
	output logic [RD_BITS-1:0] retire_rd0,
	output logic [RD_BITS-1:0] retire_rd1
);

	slot_bus_if bus ();

	tag_t head;
	tag_t tail;
	count_t free_count;
	logic disp_fire;
	dispatch_t disp_rec;
	unit_kind_e units [NUM_ENTRIES];
	logic [RD_BITS-1:0] rds [NUM_ENTRIES];

	assign disp_ready = (free_count != '0);
	assign disp_fire = disp_valid && disp_ready;
	assign disp_tag = tail;

	assign disp_rec = '{
		unit: disp_unit,
		rd: disp_rd,
		src1_valid: disp_src1_valid,
		src1_tag: disp_src1_tag,
		src2_valid: disp_src2_valid,
		src2_tag: disp_src2_tag
	};

	ring_ctrl u_ring (
		.clk(clk),
		.reset(reset),
		.disp_fire(disp_fire),
		.bus(bus.ring),
		.tail(tail),
		.head(head),
		.free_count(free_count)
	);

	for (genvar i = 0; i < NUM_ENTRIES; i++) begin : g_slot
		commit_slot #(
			.SLOT_ID(i)
		) u_slot (
			.clk(clk),
			.reset(reset),
			.disp(disp_rec),
			.bus(bus.slot),
			.ld_done_valid(ld_done_valid),
			.ld_done_tag(ld_done_tag),
			.unit(units[i]),
			.rd(rds[i])
		);
	end

	issue_select u_issue (
		.bus(bus.select),
		.head(head),
		.units(units),
		.rds(rds),
		.issue_ready(issue_ready),
		.issue_valid(issue_valid),
		.issue_tag(issue_tag),
		.issue_unit(issue_unit),
		.issue_rd(issue_rd)
	);

	retire_scan u_retire (
		.bus(bus.select),
		.head(head),
		.rds(rds),
		.retire_ready(retire_ready),
		.retire_valid(retire_valid),
		.retire_count(retire_count),
		.retire_head_tag(retire_head_tag),
		.retire_rd0(retire_rd0),
		.retire_rd1(retire_rd1)
	);

endmodule

`default_nettype wire

/* hw/retire_scan.sv */
// retire logic: counts the run of done slots from the head and ends them on acceptance
`default_nettype none
`timescale 1ns/1ps

module retire_scan
	import commit_cfg_pkg::*;
(
	slot_bus_if.select bus,
	input wire tag_t head,
	input wire logic [RD_BITS-1:0] rds [NUM_ENTRIES],
	input wire logic retire_ready,
	output logic retire_valid,
	output count_t retire_count,
	output tag_t retire_head_tag,
	output logic [RD_BITS-1:0] retire_rd0,
	output logic [RD_BITS-1:0] retire_rd1
);

	count_t run;
	slot_vec_t mark;
	logic fire;

	// stop at the first slot that is not done, in program order
	always_comb begin
		tag_t idx;
		logic stop;
		run = '0;
		mark = '0;
		stop = 1'b0;
		for (int i = 0; i < RETIRE_WIDTH; i++) begin
			idx = head + tag_t'(i);
			if (!stop && bus.done[idx]) begin
				run = run + 1'b1;
				mark[idx] = 1'b1;
			end else begin
				stop = 1'b1;
			end
		end
	end

	assign retire_valid = (run != '0);
	assign fire = retire_valid && retire_ready;

	assign retire_count = run;
	assign retire_head_tag = head;
	assign retire_rd0 = rds[head];
	assign retire_rd1 = rds[head + 1'b1];

	assign bus.ended = fire ? mark : '0;
	assign bus.retire_n = fire ? run : '0;

endmodule

`default_nettype wire

/* hw/issue_select.sv */
// issue port: picks the eligible slot closest to the head and grants it on acceptance
`default_nettype none
`timescale 1ns/1ps

module issue_select
	import commit_cfg_pkg::*;
	import commit_op_pkg::*;
(
	slot_bus_if.select bus,
	input wire tag_t head,
	input wire unit_kind_e units [NUM_ENTRIES],
	input wire logic [RD_BITS-1:0] rds [NUM_ENTRIES],
	input wire logic issue_ready,
	output logic issue_valid,
	output tag_t issue_tag,
	output unit_kind_e issue_unit,
	output logic [RD_BITS-1:0] issue_rd
);

	logic found;
	tag_t pick;

	// walk the ring from the head, first hit is the oldest
	always_comb begin
		tag_t idx;
		found = 1'b0;
		pick = head;
		for (int i = 0; i < NUM_ENTRIES; i++) begin
			idx = head + tag_t'(i);
			if (!found && bus.eligible[idx]) begin
				found = 1'b1;
				pick = idx;
			end
		end
	end

	assign issue_valid = found;
	assign issue_tag = pick;
	assign issue_unit = units[pick];
	assign issue_rd = rds[pick];

	assign bus.grant = (found && issue_ready) ? (slot_vec_t'(1) << pick) : '0;

	always_comb begin
		a_grant_onehot: assert final ($onehot0(bus.grant));
	end

endmodule

`default_nettype wire

/* hw/commit_slot.sv */
// one commit window slot: captures a dispatch, waits on operands, tracks execution, retires
`default_nettype none
`timescale 1ns/1ps

module commit_slot
	import commit_cfg_pkg::*;
	import commit_op_pkg::*;
#(
	parameter int SLOT_ID = 0
) (
	input wire logic clk,
	input wire logic reset,
	input wire dispatch_t disp,
	slot_bus_if.slot bus,
	input wire logic ld_done_valid,
	input wire tag_t ld_done_tag,
	output unit_kind_e unit,
	output logic [RD_BITS-1:0] rd
);

	slot_state_e state;
	dispatch_t rec;
	logic src1_res;
	logic src2_res;
	count_t lat_cnt;

	logic alloc_hit;
	logic grant_hit;
	logic ended_hit;
	logic ld_hit;
	logic src1_ok;
	logic src2_ok;
	logic disp_src1_ok;
	logic disp_src2_ok;

	assign alloc_hit = bus.alloc[SLOT_ID];
	assign grant_hit = bus.grant[SLOT_ID];
	assign ended_hit = bus.ended[SLOT_ID];
	assign ld_hit = ld_done_valid && (ld_done_tag == tag_t'(SLOT_ID));

	// at dispatch a source needs no wait when absent, already done, or its producer has left
	assign disp_src1_ok = !disp.src1_valid || bus.done[disp.src1_tag]
		|| !bus.occupied[disp.src1_tag];
	assign disp_src2_ok = !disp.src2_valid || bus.done[disp.src2_tag]
		|| !bus.occupied[disp.src2_tag];

	// producers stay done until retire, so the level is enough here
	assign src1_ok = src1_res || bus.done[rec.src1_tag];
	assign src2_ok = src2_res || bus.done[rec.src2_tag];

	assign bus.eligible[SLOT_ID] = (state == ST_WAIT) && src1_ok && src2_ok;
	assign bus.done[SLOT_ID] = (state == ST_DONE);
	assign bus.occupied[SLOT_ID] = (state != ST_IDLE);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ST_IDLE;
			src1_res <= 1'b0;
			src2_res <= 1'b0;
			lat_cnt <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (alloc_hit) begin
						state <= ST_WAIT;
						src1_res <= disp_src1_ok;
						src2_res <= disp_src2_ok;
					end
				end
				ST_WAIT: begin
					src1_res <= src1_ok;
					src2_res <= src2_ok;
					if (grant_hit) begin
						state <= ST_BUSY;
						lat_cnt <= count_t'(MUL_LATENCY - 1);
					end
				end
				ST_BUSY: begin
					case (rec.unit)
						UNIT_ALU: state <= ST_DONE;
						UNIT_MUL: begin
							if (lat_cnt == '0) begin
								state <= ST_DONE;
							end else begin
								lat_cnt <= lat_cnt - 1'b1;
							end
						end
						UNIT_LOAD: begin
							// load latency is whatever the memory side says
							if (ld_hit) begin
								state <= ST_DONE;
							end
						end
						default: state <= ST_DONE;
					endcase
				end
				ST_DONE: begin
					if (ended_hit) begin
						state <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (alloc_hit) begin
			rec <= disp;
		end
	end

	assign unit = rec.unit;
	assign rd = rec.rd;

	a_grant_needs_eligible: assert property (@(posedge clk) disable iff (reset)
		grant_hit |-> bus.eligible[SLOT_ID]);

	// load completion from outside must name a load that is in flight
	a_ld_done_target: assert property (@(posedge clk) disable iff (reset)
		ld_hit |-> (state == ST_BUSY) && (rec.unit == UNIT_LOAD));

endmodule

`default_nettype wire

/* hw/ring_ctrl.sv */
// ring bookkeeping for the commit window: head, tail and number of free slots
`default_nettype none
`timescale 1ns/1ps

module ring_ctrl
	import commit_cfg_pkg::*;
(
	input wire logic clk,
	input wire logic reset,
	input wire logic disp_fire,
	slot_bus_if.ring bus,
	output tag_t tail,
	output tag_t head,
	output count_t free_count
);

	tag_t head_q;
	tag_t tail_q;
	count_t free_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			head_q <= '0;
			tail_q <= '0;
			free_q <= count_t'(NUM_ENTRIES);
		end else begin
			// tag_t wraps on its own since NUM_ENTRIES is a power of two
			if (disp_fire) begin
				tail_q <= tail_q + 1'b1;
			end
			head_q <= head_q + tag_t'(bus.retire_n);
			free_q <= free_q + bus.retire_n - count_t'(disp_fire);
		end
	end

	// new slot is always the one at the tail
	assign bus.alloc = disp_fire ? (slot_vec_t'(1) << tail_q) : '0;

	assign head = head_q;
	assign tail = tail_q;
	assign free_count = free_q;

	a_free_bound: assert property (@(posedge clk) disable iff (reset)
		free_q <= count_t'(NUM_ENTRIES));

	a_no_disp_when_full: assert property (@(posedge clk) disable iff (reset)
		disp_fire |-> (free_q != '0));

endmodule

`default_nettype wire

/* hw/slot_bus_if.sv */
// per-slot status and control vectors shared by the ring, the slots, the selector and retire
`default_nettype none
`timescale 1ns/1ps

interface slot_bus_if
	import commit_cfg_pkg::*;
();

	// one-hot at the tail on a dispatch fire
	slot_vec_t alloc;
	// slot holds a finished result
	slot_vec_t done;
	// slot holds an instruction (anything but idle)
	slot_vec_t occupied;
	// waiting with both operands available
	slot_vec_t eligible;
	// one-hot on an issue fire
	slot_vec_t grant;
	// slots leaving the window this cycle
	slot_vec_t ended;
	count_t retire_n;

	modport ring (output alloc, input ended, input retire_n);

	// each slot drives its own bit of done, occupied and eligible and reads the rest
	modport slot (input alloc, input grant, input ended, output done, output occupied,
		output eligible);

	// used by both the issue selector and the retire scan
	modport select (input eligible, input done, output grant, output ended, output retire_n);

endinterface

`default_nettype wire

/* hw/commit_op_pkg.sv */
// unit kinds, slot lifecycle states and the record carried from dispatch into a slot
`default_nettype none

package commit_op_pkg;

	import commit_cfg_pkg::*;

	// execution unit the instruction is sent to
	typedef enum logic [1:0] {
		UNIT_ALU  = 2'd0,
		UNIT_MUL  = 2'd1,
		UNIT_LOAD = 2'd2
	} unit_kind_e;

	// slot lifecycle
	// idle -> wait (operands) -> busy (executing) -> done (until retired)
	typedef enum logic [1:0] {
		ST_IDLE = 2'd0,
		ST_WAIT = 2'd1,
		ST_BUSY = 2'd2,
		ST_DONE = 2'd3
	} slot_state_e;

	// 15 bits: unit, rd, and two optional producer tags
	typedef struct packed {
		unit_kind_e unit;
		logic [RD_BITS-1:0] rd;
		logic src1_valid;
		tag_t src1_tag;
		logic src2_valid;
		tag_t src2_tag;
	} dispatch_t;

endpackage

`default_nettype wire

/* hw/commit_cfg_pkg.sv */
// commit window sizing constants and the index and vector types built from them
`default_nettype none

package commit_cfg_pkg;

	// slots in the ring
	localparam int NUM_ENTRIES = 8;
	// bits needed to name one slot
	localparam int TAG_BITS = 3;
	// most slots handed to the register file per cycle
	localparam int RETIRE_WIDTH = 2;
	// multiplier issue to completion, in cycles
	localparam int MUL_LATENCY = 2;
	// architectural destination register number
	localparam int RD_BITS = 5;

	typedef logic [TAG_BITS-1:0] tag_t;

	// one extra bit so a full window (NUM_ENTRIES) fits
	typedef logic [TAG_BITS:0] count_t;

	// one bit per slot
	typedef logic [NUM_ENTRIES-1:0] slot_vec_t;

endpackage

`default_nettype wire
